// ==== rtl/delay_cmd_decoder.sv ====
/*
 * delay command decoder.
 * registers host commands into per-lane load strobes and one apply pulse,
 * and rejects loads whose fine tap is out of range.
 */
`include "odelay_macros.svh"

module delay_cmd_decoder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_valid,
    input  odelay_cmd_pkg::delay_cmd_t   cmd,
    output odelay_lane_pkg::lane_strobe_t lane_ld,
    output odelay_lane_pkg::delay_code_t ld_code,
    output logic                         apply,
    output logic                         cmd_err
);
    import odelay_cmd_pkg::*;
    import odelay_lane_pkg::*;

    lane_strobe_t ld_next;    // load strobes for the next cycle.
    logic         apply_next; // apply pulse for the next cycle.
    logic         err_next;   // rejected load.
    logic         fine_ok;    // fine tap of the incoming code is legal.

    assign fine_ok = (cmd.code.fine <= `ODELAY_FINE_MAX);

    // opcode decode, nothing happens without cmd_valid.
    always_comb begin
        ld_next    = '0;
        apply_next = 1'b0;
        err_next   = 1'b0;
        if (cmd_valid) begin
            case (cmd.op)
                CMD_LOAD: begin
                    if (fine_ok) begin
                        ld_next[cmd.lane] = 1'b1; // one-hot to the target lane.
                    end else begin
                        err_next = 1'b1;
                    end
                end
                CMD_LOAD_ALL: begin
                    if (fine_ok) begin
                        ld_next = '1; // broadcast to every lane.
                    end else begin
                        err_next = 1'b1;
                    end
                end
                CMD_APPLY: apply_next = 1'b1;
                default: ; // CMD_NOP.
            endcase
        end
    end

    // strobes are high for exactly the cycle after the command.
    always_ff @(posedge clk) begin
        if (rst) begin
            lane_ld <= '0;
            apply   <= 1'b0;
            cmd_err <= 1'b0;
        end else begin
            lane_ld <= ld_next;
            apply   <= apply_next;
            cmd_err <= err_next;
        end
    end

    // code travels alongside the strobes.
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            ld_code <= cmd.code;
        end
    end

    // a rejected load must not reach the register bank.
    a_no_load_on_err: assert property (@(posedge clk) disable iff (rst)
        !((|lane_ld) && cmd_err));

    // one opcode per command, so apply and loads never share a cycle.
    a_apply_excl_load: assert property (@(posedge clk) disable iff (rst)
        !(apply && (|lane_ld)));

endmodule

// ==== rtl/delay_line_model.sv ====
/*
 * behavioural output delay line.
 * each lane shifts its data into a history and registers the tap picked
 * by the active coarse count, giving coarse + 1 cycles of delay.
 */
`include "odelay_macros.svh"

module delay_line_model (
    input  logic                            clk,
    input  logic                            rst,
    input  odelay_lane_pkg::lane_codes_t    active_codes,
    input  logic [`ODELAY_NUM_LANES-1:0]    data_in,
    output logic [`ODELAY_NUM_LANES-1:0]    data_out
);
    // edges since reset, saturating, used to qualify the delay check.
    logic [$clog2(`ODELAY_HIST_DEPTH):0] fill_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt <= '0;
        end else if (fill_cnt != `ODELAY_HIST_DEPTH) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    for (genvar g = 0; g < `ODELAY_NUM_LANES; g++) begin : g_lane
        logic [`ODELAY_HIST_DEPTH-2:0] hist; // past samples, bit 0 newest.
        logic [`ODELAY_HIST_DEPTH-1:0] taps; // tap 0 is the live input.
        logic                          dout_q;

        assign taps = {hist, data_in[g]};

        always_ff @(posedge clk) begin
            if (rst) begin
                hist   <= '0;
                dout_q <= 1'b0;
            end else begin
                hist   <= taps[`ODELAY_HIST_DEPTH-2:0];       // shift by one.
                dout_q <= taps[active_codes[g].coarse];       // coarse tap select.
            end
        end

        assign data_out[g] = dout_q;

        // one check per coarse value, since $past needs a constant depth.
        // the window must lie fully after reset.
        for (genvar c = 0; c < `ODELAY_HIST_DEPTH; c++) begin : g_tap
            a_tap_delay: assert property (@(posedge clk) disable iff (rst)
                ((fill_cnt > c) && ($past(active_codes[g].coarse) == 5'(c)))
                |-> (data_out[g] == $past(data_in[g], c + 1)));
        end
    end

endmodule

// ==== rtl/odelay_cmd_pkg.sv ====
/*
 * host command types of the output delay controller.
 * opcode enum and the command word carried with cmd_valid.
 */
`include "odelay_macros.svh"

package odelay_cmd_pkg;

    // lane index width, at least one bit.
    localparam int LANE_W = (`ODELAY_NUM_LANES > 1) ? $clog2(`ODELAY_NUM_LANES) : 1;

    // host command opcodes.
    typedef enum logic [1:0] {
        CMD_NOP      = 2'd0, // idle.
        CMD_LOAD     = 2'd1, // stage a code for one lane.
        CMD_LOAD_ALL = 2'd2, // stage the same code for every lane.
        CMD_APPLY    = 2'd3  // copy all staged codes to active.
    } cmd_op_e;

    // command word, only meaningful while cmd_valid is high.
    typedef struct packed {
        cmd_op_e                    op;   // what to do.
        logic [LANE_W-1:0]          lane; // target lane for CMD_LOAD.
        odelay_lane_pkg::delay_code_t code; // code for the load commands.
    } delay_cmd_t;

endpackage

// ==== rtl/odelay_ctrl_top.sv ====
/*
 * output delay controller top.
 * command decoder, delay register bank and behavioural delay line.
 */
`include "odelay_macros.svh"

module odelay_ctrl_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,
    input  odelay_cmd_pkg::delay_cmd_t    cmd,
    input  logic [`ODELAY_NUM_LANES-1:0]  data_in,
    output logic [`ODELAY_NUM_LANES-1:0]  data_out,
    output odelay_lane_pkg::lane_codes_t  active_codes,
    output logic                          cmd_err
);
    import odelay_lane_pkg::*;

    lane_strobe_t lane_ld; // per-lane load strobes.
    delay_code_t  ld_code; // code for the staging registers.
    logic         apply;   // staging to active copy.

    delay_cmd_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .lane_ld   (lane_ld),
        .ld_code   (ld_code),
        .apply     (apply),
        .cmd_err   (cmd_err)
    );

    odelay_fine_pipe u_regs (
        .clk          (clk),
        .rst          (rst),
        .lane_ld      (lane_ld),
        .ld_code      (ld_code),
        .apply        (apply),
        .active_codes (active_codes)
    );

    delay_line_model u_dline (
        .clk          (clk),
        .rst          (rst),
        .active_codes (active_codes), // also read back at the port.
        .data_in      (data_in),
        .data_out     (data_out)
    );

endmodule

// ==== rtl/odelay_fine_pipe.sv ====
/*
 * delay register bank.
 * per-lane staging code written on a load strobe, active code taken
 * from staging on apply, all lanes switch in the same cycle.
 */
`include "odelay_macros.svh"

module odelay_fine_pipe (
    input  logic                          clk,
    input  logic                          rst,
    input  odelay_lane_pkg::lane_strobe_t lane_ld,
    input  odelay_lane_pkg::delay_code_t  ld_code,
    input  logic                          apply,
    output odelay_lane_pkg::lane_codes_t  active_codes
);
    import odelay_lane_pkg::*;

    lane_codes_t stage_codes; // staged codes, not yet visible.

    // staging registers, one per lane.
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_codes <= {`ODELAY_NUM_LANES{`ODELAY_RESET_CODE}};
        end else begin
            for (int i = 0; i < `ODELAY_NUM_LANES; i++) begin
                if (lane_ld[i]) begin
                    stage_codes[i] <= ld_code;
                end
            end
        end
    end

    // active registers.
    // on a same-cycle load the old staging value is taken.
    always_ff @(posedge clk) begin
        if (rst) begin
            active_codes <= {`ODELAY_NUM_LANES{`ODELAY_RESET_CODE}};
        end else if (apply) begin
            active_codes <= stage_codes; // all lanes at once.
        end
    end

    // the decoder filter must keep every staged fine tap legal.
    for (genvar g = 0; g < `ODELAY_NUM_LANES; g++) begin : g_chk
        a_stage_fine_legal: assert property (@(posedge clk) disable iff (rst)
            stage_codes[g].fine <= `ODELAY_FINE_MAX);
    end

endmodule

// ==== rtl/odelay_lane_pkg.sv ====
/*
 * lane-side types of the output delay controller.
 * delay code layout and the per-lane strobe and code vectors.
 */
`include "odelay_macros.svh"

package odelay_lane_pkg;

    // 8-bit delay code, same bit layout as the hardware delay word.
    typedef struct packed {
        logic [4:0] coarse; // bits 7:3, whole-cycle taps in the model.
        logic [2:0] fine;   // bits 2:0, must stay below 5.
    } delay_code_t;

    // one load strobe bit per lane.
    typedef logic [`ODELAY_NUM_LANES-1:0] lane_strobe_t;

    // one delay code per lane, lane 0 in the low byte.
    typedef delay_code_t [`ODELAY_NUM_LANES-1:0] lane_codes_t;

endpackage

// ==== rtl/odelay_macros.svh ====
/*
 * output delay control parameters.
 * lane count, reset code, fine tap limit and delay-line history depth.
 */
`ifndef ODELAY_MACROS_SVH
`define ODELAY_MACROS_SVH

// number of single-bit output lanes.
`define ODELAY_NUM_LANES 4

// code loaded into every staging and active register on reset.
// coarse 1, fine 2.
`define ODELAY_RESET_CODE 8'h0A

// largest legal fine tap, the hardware fine stage has five positions.
`define ODELAY_FINE_MAX 3'd4

// history bits per lane, one per coarse tap (0 to 31).
`define ODELAY_HIST_DEPTH 32

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the output delay controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_odelay_ctrl -f tb.f -o sim_odelay

./obj_dir/sim_odelay 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== tb.f ====
+incdir+rtl
rtl/odelay_lane_pkg.sv
rtl/odelay_cmd_pkg.sv
rtl/delay_cmd_decoder.sv
rtl/odelay_fine_pipe.sv
rtl/delay_line_model.sv
rtl/odelay_ctrl_top.sv
verification/tb_odelay_ctrl.sv

// ==== verification/tb_odelay_ctrl.sv ====
/*
 * testbench for the output delay controller.
 * drives host commands and lane data, keeps a reference model of the
 * staging/active codes and the delay line, and checks the DUT against it.
 */
`include "odelay_macros.svh"

module tb_odelay_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    import odelay_cmd_pkg::*;
    import odelay_lane_pkg::*;

    localparam int NL = `ODELAY_NUM_LANES;
    localparam int MAX_CYCLES = 600; // sequence runs about 400 cycles.

    logic                 clk;
    logic                 rst;
    logic                 cmd_valid;
    delay_cmd_t           cmd;
    logic [NL-1:0]        data_in;
    logic [NL-1:0]        data_out;
    lane_codes_t          active_codes;
    logic                 cmd_err;

    integer seed = 32'h29d2f6ef;
    int     err_cnt = 0;
    int     cycles = 0;
    logic   data_on = 1'b0; // random lane data enabled.

    // reference model state.
    lane_strobe_t m_ld;      // load strobes one cycle after the command.
    logic         m_apply;
    logic         m_err;
    delay_code_t  m_code;
    lane_codes_t  m_stage;
    lane_codes_t  m_active;
    logic [31:0]  m_hist [NL]; // bit 0 is the sample of the previous edge.
    logic [NL-1:0] m_dout;

    odelay_ctrl_top u_odelay_ctrl_top (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .data_in      (data_in),
        .data_out     (data_out),
        .active_codes (active_codes),
        .cmd_err      (cmd_err)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk; // 20 ns period.

    // model built from the command rules: one cycle to the strobes, one more to the registers.
    always_ff @(posedge clk) begin
        if (rst) begin
            m_ld     <= '0;
            m_apply  <= 1'b0;
            m_err    <= 1'b0;
            m_stage  <= {NL{`ODELAY_RESET_CODE}};
            m_active <= {NL{`ODELAY_RESET_CODE}};
            m_dout   <= '0;
            for (int l = 0; l < NL; l++) m_hist[l] <= '0;
        end else begin
            m_ld    <= '0;
            m_apply <= 1'b0;
            m_err   <= 1'b0;
            if (cmd_valid && (cmd.op == CMD_LOAD || cmd.op == CMD_LOAD_ALL)) begin
                m_code <= cmd.code;
                if (cmd.code.fine > `ODELAY_FINE_MAX) m_err <= 1'b1; // rejected load.
                else if (cmd.op == CMD_LOAD) m_ld[cmd.lane] <= 1'b1;
                else m_ld <= '1;
            end else if (cmd_valid && cmd.op == CMD_APPLY) begin
                m_apply <= 1'b1;
            end
            for (int l = 0; l < NL; l++) begin
                if (m_ld[l]) m_stage[l] <= m_code;
            end
            if (m_apply) m_active <= m_stage; // old staging wins on a same-cycle load.
            for (int l = 0; l < NL; l++) begin
                if (m_active[l].coarse == 5'd0) m_dout[l] <= data_in[l];
                else m_dout[l] <= m_hist[l][m_active[l].coarse - 5'd1];
                m_hist[l] <= {m_hist[l][30:0], data_in[l]};
            end
        end
    end

    a_active_codes: assert property (@(posedge clk) disable iff (rst) active_codes == m_active)
        else begin
            err_cnt++;
            $display("ERR t=%0t active_codes exp=%h got=%h", $time,
                     $sampled(m_active), $sampled(active_codes));
        end

    a_cmd_err: assert property (@(posedge clk) disable iff (rst) cmd_err == m_err)
        else begin
            err_cnt++;
            $display("ERR t=%0t cmd_err exp=%b got=%b", $time, $sampled(m_err), $sampled(cmd_err));
        end

    a_data_out: assert property (@(posedge clk) disable iff (rst) data_out == m_dout)
        else begin
            err_cnt++;
            $display("ERR t=%0t data_out exp=%b got=%b", $time,
                     $sampled(m_dout), $sampled(data_out));
        end

    // run limit.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: sequence did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic delay_code_t make_code(logic [4:0] coarse, logic [2:0] fine);
        delay_code_t c;
        c.coarse = coarse;
        c.fine   = fine;
        return c;
    endfunction

    // one cycle, fresh lane data at the falling edge.
    task automatic step();
        int r;
        @(negedge clk);
        if (data_on) begin
            r = $random(seed);
            data_in = r[NL-1:0];
        end
    endtask

    task automatic idle(int n);
        repeat (n) step();
    endtask

    // one-cycle command pulse, call at a falling edge.
    task automatic issue(cmd_op_e op, logic [LANE_W-1:0] lane, delay_code_t code);
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.lane  = lane;
        cmd.code  = code;
        step();
        cmd_valid = 1'b0;
    endtask

    initial begin
        int r;
        logic [2:0] fine;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        data_in   = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        idle(5); // reset values hold, data still zero.

        issue(CMD_LOAD, LANE_W'(2), make_code(5'd7, 3'd3));
        idle(4); // staged only.
        issue(CMD_APPLY, '0, '0);
        idle(4);

        issue(CMD_LOAD_ALL, '0, make_code(5'd3, 3'd4));
        issue(CMD_APPLY, '0, '0); // back to back.
        idle(4);

        for (int f = 5; f < 8; f++) begin
            issue(CMD_LOAD, LANE_W'(1), make_code(5'd20, 3'(f)));
            idle(3);
        end
        issue(CMD_LOAD_ALL, '0, make_code(5'd9, 3'd6));
        idle(3);
        issue(CMD_APPLY, '0, '0); // staging must be unchanged.
        idle(3);

        data_on = 1'b1;
        for (int k = 0; k < 8; k++) begin
            for (int l = 0; l < NL; l++) begin
                r = $random(seed);
                fine = r[2:0];
                if (fine > `ODELAY_FINE_MAX) fine = fine - 3'd4;
                issue(CMD_LOAD, LANE_W'(l), make_code(r[12:8], fine));
            end
            issue(CMD_APPLY, '0, '0);
            idle(36); // longer than the deepest coarse setting.
        end

        issue(CMD_LOAD, LANE_W'(0), make_code(5'd2, 3'd1));
        issue(CMD_APPLY, '0, '0);
        issue(CMD_LOAD, LANE_W'(0), make_code(5'd11, 3'd0)); // stays staged.
        idle(4);
        issue(CMD_LOAD_ALL, '0, make_code(5'd4, 3'd2));
        issue(CMD_APPLY, '0, '0);
        issue(CMD_LOAD_ALL, '0, make_code(5'd6, 3'd3));
        idle(4);

        $display("run done: %0d cycles, %0d errors", cycles, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
